// File: hw/mips_pkg.sv
//*************************************************
// shared core types: opcode and function codes,
// control selects and the instruction word union
//*************************************************

package mips_pkg;

   typedef logic [31:0] word_t;      // data word
   typedef logic [4:0]  reg_addr_t;  // register number

   localparam reg_addr_t link_reg = 5'd31;  // jal destination

   // primary opcodes
   localparam logic [5:0] op_special = 6'h00;
   localparam logic [5:0] op_j       = 6'h02;
   localparam logic [5:0] op_jal     = 6'h03;
   localparam logic [5:0] op_beq     = 6'h04;
   localparam logic [5:0] op_bne     = 6'h05;
   localparam logic [5:0] op_addiu   = 6'h09;
   localparam logic [5:0] op_slti    = 6'h0a;
   localparam logic [5:0] op_andi    = 6'h0c;
   localparam logic [5:0] op_ori     = 6'h0d;
   localparam logic [5:0] op_xori    = 6'h0e;
   localparam logic [5:0] op_lui     = 6'h0f;
   localparam logic [5:0] op_lw      = 6'h23;
   localparam logic [5:0] op_sw      = 6'h2b;

   // funct field under op_special
   localparam logic [5:0] fn_sll     = 6'h00;
   localparam logic [5:0] fn_srl     = 6'h02;
   localparam logic [5:0] fn_sra     = 6'h03;
   localparam logic [5:0] fn_sllv    = 6'h04;
   localparam logic [5:0] fn_srlv    = 6'h06;
   localparam logic [5:0] fn_srav    = 6'h07;
   localparam logic [5:0] fn_jr      = 6'h08;
   localparam logic [5:0] fn_syscall = 6'h0c;
   localparam logic [5:0] fn_addu    = 6'h21;
   localparam logic [5:0] fn_subu    = 6'h23;
   localparam logic [5:0] fn_and     = 6'h24;
   localparam logic [5:0] fn_or      = 6'h25;
   localparam logic [5:0] fn_xor     = 6'h26;
   localparam logic [5:0] fn_nor     = 6'h27;
   localparam logic [5:0] fn_slt     = 6'h2a;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor,
      alu_nor, alu_slt, alu_sll, alu_srl, alu_sra
   } alu_sel_e;

   typedef enum logic [1:0] {
      wb_alu, wb_load, wb_upper, wb_link  // upper = lui value
   } wb_sel_e;

   typedef enum logic [1:0] {
      pc_seq, pc_branch, pc_reg, pc_jump
   } pc_sel_e;

   typedef struct packed {
      logic [5:0] op;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } r_fmt_t;

   typedef struct packed {
      logic [5:0]  op;
      reg_addr_t   rs;
      reg_addr_t   rt;
      logic [15:0] imm;
   } i_fmt_t;

   typedef struct packed {
      logic [5:0]  op;
      logic [25:0] target;
   } j_fmt_t;

   // one instruction word, three field layouts
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      j_fmt_t j;
   } instr_u;

endpackage

// File: hw/fetch_stage.sv
//*************************************************
// fetch stage: pc pair with delay slot sequencing
//*************************************************
`timescale 1ns/1ps

module fetch_stage #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic              clk,
   input  logic              rst_b,
   input  logic              halted,
   input  mips_pkg::pc_sel_e pc_sel,
   input  mips_pkg::word_t   branch_target,
   input  mips_pkg::word_t   jump_target,
   input  mips_pkg::word_t   reg_target,   // jr source
   output mips_pkg::word_t   pc,
   output mips_pkg::word_t   pc_plus8
);

   mips_pkg::word_t npc;       // delay slot address
   mips_pkg::word_t npc_next;

   // target lands in npc, so it is fetched after the delay slot
   always_comb begin
      case (pc_sel)
         mips_pkg::pc_branch: npc_next = branch_target;
         mips_pkg::pc_reg:    npc_next = reg_target;
         mips_pkg::pc_jump:   npc_next = jump_target;
         default:             npc_next = npc + 32'd4;  // sequential
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc  <= text_start;
         npc <= text_start + 32'd4;
      end else if (!halted) begin  // frozen once halted
         pc  <= npc;
         npc <= npc_next;
      end
   end

   assign pc_plus8 = pc + 32'd8;  // link skips the delay slot

endmodule

// File: hw/decode_stage.sv
//*************************************************
// decode stage: control levels and immediate
//*************************************************
`timescale 1ns/1ps

module decode_stage (
   input  mips_pkg::instr_u   inst,
   output mips_pkg::alu_sel_e alu_sel,
   output logic               use_imm,
   output logic               zero_ext,
   output logic               shift_var,
   output logic               reg_dst_rd,
   output logic               reg_write,
   output mips_pkg::wb_sel_e  wb_sel,
   output logic               mem_write,
   output mips_pkg::pc_sel_e  pc_sel_jump,  // unconditional redirect only
   output logic               is_branch,
   output logic               branch_ne,
   output logic               syscall,
   output logic               reserved,
   output mips_pkg::word_t    imm_ext
);

   always_comb begin
      // default is a nop with no side effects
      alu_sel     = mips_pkg::alu_add;
      use_imm     = 1'b0;
      zero_ext    = 1'b0;
      shift_var   = 1'b0;
      reg_dst_rd  = 1'b0;
      reg_write   = 1'b0;
      wb_sel      = mips_pkg::wb_alu;
      mem_write   = 1'b0;
      pc_sel_jump = mips_pkg::pc_seq;
      is_branch   = 1'b0;
      branch_ne   = 1'b0;
      syscall     = 1'b0;
      reserved    = 1'b0;

      case (inst.r.op)
         mips_pkg::op_special: begin
            reg_dst_rd = 1'b1;
            reg_write  = 1'b1;  // cleared below for jr, syscall, unknown
            case (inst.r.funct)
               mips_pkg::fn_addu: alu_sel = mips_pkg::alu_add;
               mips_pkg::fn_subu: alu_sel = mips_pkg::alu_sub;
               mips_pkg::fn_and:  alu_sel = mips_pkg::alu_and;
               mips_pkg::fn_or:   alu_sel = mips_pkg::alu_or;
               mips_pkg::fn_xor:  alu_sel = mips_pkg::alu_xor;
               mips_pkg::fn_nor:  alu_sel = mips_pkg::alu_nor;
               mips_pkg::fn_slt:  alu_sel = mips_pkg::alu_slt;
               mips_pkg::fn_sll:  alu_sel = mips_pkg::alu_sll;
               mips_pkg::fn_srl:  alu_sel = mips_pkg::alu_srl;
               mips_pkg::fn_sra:  alu_sel = mips_pkg::alu_sra;
               mips_pkg::fn_sllv: begin
                  alu_sel   = mips_pkg::alu_sll;
                  shift_var = 1'b1;  // amount from rs
               end
               mips_pkg::fn_srlv: begin
                  alu_sel   = mips_pkg::alu_srl;
                  shift_var = 1'b1;
               end
               mips_pkg::fn_srav: begin
                  alu_sel   = mips_pkg::alu_sra;
                  shift_var = 1'b1;
               end
               mips_pkg::fn_jr: begin
                  reg_write   = 1'b0;
                  pc_sel_jump = mips_pkg::pc_reg;
               end
               mips_pkg::fn_syscall: begin
                  reg_write = 1'b0;
                  syscall   = 1'b1;  // any syscall halts
               end
               default: begin
                  reg_write = 1'b0;
                  reserved  = 1'b1;
               end
            endcase
         end
         mips_pkg::op_addiu: begin
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::op_slti: begin
            alu_sel   = mips_pkg::alu_slt;
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::op_andi: begin
            alu_sel   = mips_pkg::alu_and;
            use_imm   = 1'b1;
            zero_ext  = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::op_ori: begin
            alu_sel   = mips_pkg::alu_or;
            use_imm   = 1'b1;
            zero_ext  = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::op_xori: begin
            alu_sel   = mips_pkg::alu_xor;
            use_imm   = 1'b1;
            zero_ext  = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::op_lui: begin
            reg_write = 1'b1;
            wb_sel    = mips_pkg::wb_upper;  // alu result unused
         end
         mips_pkg::op_lw: begin
            use_imm   = 1'b1;  // base + offset
            reg_write = 1'b1;
            wb_sel    = mips_pkg::wb_load;
         end
         mips_pkg::op_sw: begin
            use_imm   = 1'b1;
            mem_write = 1'b1;
         end
         mips_pkg::op_beq: is_branch = 1'b1;
         mips_pkg::op_bne: begin
            is_branch = 1'b1;
            branch_ne = 1'b1;
         end
         mips_pkg::op_j: pc_sel_jump = mips_pkg::pc_jump;
         mips_pkg::op_jal: begin
            pc_sel_jump = mips_pkg::pc_jump;
            reg_write   = 1'b1;
            wb_sel      = mips_pkg::wb_link;  // also forces link_reg dest
         end
         default: reserved = 1'b1;
      endcase
   end

   // logical immediates zero extended, rest sign extended
   assign imm_ext = zero_ext ? {16'h0000, inst.i.imm}
                             : {{16{inst.i.imm[15]}}, inst.i.imm};

endmodule

// File: hw/regfile.sv
//*************************************************
// register file: 32 x 32, 2 read, 1 write
//*************************************************
`timescale 1ns/1ps

module regfile (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::reg_addr_t rs_addr,
   input  mips_pkg::reg_addr_t rt_addr,
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data,
   input  mips_pkg::reg_addr_t wr_addr,
   input  mips_pkg::word_t     wr_data,
   input  logic                wr_en
);

   mips_pkg::word_t regs [32];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != 5'd0)) begin  // r0 stays zero
         regs[wr_addr] <= wr_data;
      end
   end

   // asynchronous reads
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

endmodule

// File: hw/execute_stage.sv
//*************************************************
// execute stage: alu, branch resolve, targets
//*************************************************
`timescale 1ns/1ps

module execute_stage (
   input  mips_pkg::instr_u   inst,
   input  mips_pkg::word_t    pc,
   input  mips_pkg::word_t    rs_data,
   input  mips_pkg::word_t    rt_data,
   input  mips_pkg::word_t    imm_ext,
   input  mips_pkg::alu_sel_e alu_sel,
   input  logic               use_imm,
   input  logic               shift_var,
   input  logic               is_branch,
   input  logic               branch_ne,
   input  mips_pkg::pc_sel_e  pc_sel_jump,
   output mips_pkg::word_t    alu_out,
   output mips_pkg::pc_sel_e  pc_sel,
   output mips_pkg::word_t    branch_target,
   output mips_pkg::word_t    jump_target
);

   mips_pkg::word_t op_b;    // rt or immediate
   logic [4:0]      sh_amt;  // shamt field or rs[4:0]
   logic            taken;

   assign op_b   = use_imm ? imm_ext : rt_data;
   assign sh_amt = shift_var ? rs_data[4:0] : inst.r.shamt;

   always_comb begin
      case (alu_sel)
         mips_pkg::alu_add: alu_out = rs_data + op_b;  // wraps with no overflow trap
         mips_pkg::alu_sub: alu_out = rs_data - op_b;
         mips_pkg::alu_and: alu_out = rs_data & op_b;
         mips_pkg::alu_or:  alu_out = rs_data | op_b;
         mips_pkg::alu_xor: alu_out = rs_data ^ op_b;
         mips_pkg::alu_nor: alu_out = ~(rs_data | op_b);
         mips_pkg::alu_slt: alu_out = {31'b0, $signed(rs_data) < $signed(op_b)};
         // shifts always act on rt
         mips_pkg::alu_sll: alu_out = op_b << sh_amt;
         mips_pkg::alu_srl: alu_out = op_b >> sh_amt;
         mips_pkg::alu_sra: alu_out = $signed(op_b) >>> sh_amt;
         default:           alu_out = '0;
      endcase
   end

   // beq and bne resolve on equality with the sense flipped for bne
   assign taken  = is_branch & ((rs_data == rt_data) ^ branch_ne);
   assign pc_sel = taken ? mips_pkg::pc_branch : pc_sel_jump;

   assign branch_target = pc + 32'd4 + {imm_ext[29:0], 2'b00};
   assign jump_target   = {pc[31:28], inst.j.target, 2'b00};  // same 256MB region

endmodule

// File: hw/writeback_stage.sv
//*************************************************
// writeback: result and dest select, halt flag
//*************************************************
`timescale 1ns/1ps

module writeback_stage (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::wb_sel_e   wb_sel,
   input  logic                reg_write,
   input  logic                reg_dst_rd,
   input  mips_pkg::reg_addr_t rt_addr,
   input  mips_pkg::reg_addr_t rd_addr,
   input  mips_pkg::word_t     alu_out,
   input  mips_pkg::word_t     load_data,
   input  mips_pkg::word_t     imm_ext,
   input  mips_pkg::word_t     pc_plus8,
   input  logic                syscall,
   input  logic                reserved,
   input  logic                inst_excpt,
   output mips_pkg::reg_addr_t wr_addr,
   output mips_pkg::word_t     wr_data,
   output logic                wr_en,
   output logic                halted
);

   logic halt_cause;

   assign halt_cause = syscall | reserved | inst_excpt;

   always_comb begin
      case (wb_sel)
         mips_pkg::wb_load:  wr_data = load_data;
         mips_pkg::wb_upper: wr_data = {imm_ext[15:0], 16'h0000};  // lui
         mips_pkg::wb_link:  wr_data = pc_plus8;
         default:            wr_data = alu_out;
      endcase
   end

   // link writes always go to r31
   assign wr_addr = (wb_sel == mips_pkg::wb_link) ? mips_pkg::link_reg
                  : (reg_dst_rd ? rd_addr : rt_addr);

   // halting instr itself writes nothing
   assign wr_en = reg_write & ~halted & ~halt_cause;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b)
         halted <= 1'b0;
      else if (halt_cause)
         halted <= 1'b1;  // sticky until reset
   end

endmodule

// File: hw/mips_core.sv
//*************************************************
// mips core top: stages, regfile, memory ports
//*************************************************
`timescale 1ns/1ps

module mips_core #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000  // reset pc
) (
   input  logic            clk,
   input  logic            rst_b,
   output logic [29:0]     inst_addr,   // word address
   input  mips_pkg::word_t inst,
   input  logic            inst_excpt,  // fetch fault
   output logic [29:0]     mem_addr,
   output mips_pkg::word_t mem_data_in,
   input  mips_pkg::word_t mem_data_out,
   output logic            mem_write,
   output logic            halted
);

   mips_pkg::instr_u    inst_u;
   mips_pkg::word_t     pc, pc_plus8;
   mips_pkg::word_t     rs_data, rt_data, imm_ext, alu_out;
   mips_pkg::word_t     branch_target, jump_target;
   mips_pkg::word_t     wr_data;
   mips_pkg::reg_addr_t wr_addr;
   mips_pkg::alu_sel_e  alu_sel;
   mips_pkg::wb_sel_e   wb_sel;
   mips_pkg::pc_sel_e   pc_sel, pc_sel_jump;
   logic                use_imm, shift_var, reg_dst_rd, reg_write, dcd_mem_write;
   logic                is_branch, branch_ne, syscall, reserved, wr_en;

   assign inst_u      = inst;
   assign inst_addr   = pc[31:2];
   assign mem_addr    = alu_out[31:2];  // store / load address
   assign mem_data_in = rt_data;
   // no store once halted or from a faulted fetch
   assign mem_write   = dcd_mem_write & ~halted & ~inst_excpt;

   fetch_stage #(
      .text_start(text_start)
   ) i_fetch_stage (
      .clk          (clk),
      .rst_b        (rst_b),
      .halted       (halted),
      .pc_sel       (pc_sel),
      .branch_target(branch_target),
      .jump_target  (jump_target),
      .reg_target   (rs_data),
      .pc           (pc),
      .pc_plus8     (pc_plus8)
   );

   decode_stage i_decode_stage (
      .inst       (inst_u),
      .alu_sel    (alu_sel),
      .use_imm    (use_imm),
      .zero_ext   (),          // folded into imm_ext
      .shift_var  (shift_var),
      .reg_dst_rd (reg_dst_rd),
      .reg_write  (reg_write),
      .wb_sel     (wb_sel),
      .mem_write  (dcd_mem_write),
      .pc_sel_jump(pc_sel_jump),
      .is_branch  (is_branch),
      .branch_ne  (branch_ne),
      .syscall    (syscall),
      .reserved   (reserved),
      .imm_ext    (imm_ext)
   );

   regfile i_regfile (
      .clk    (clk),
      .rst_b  (rst_b),
      .rs_addr(inst_u.r.rs),
      .rt_addr(inst_u.r.rt),
      .rs_data(rs_data),
      .rt_data(rt_data),
      .wr_addr(wr_addr),
      .wr_data(wr_data),
      .wr_en  (wr_en)
   );

   execute_stage i_execute_stage (
      .inst         (inst_u),
      .pc           (pc),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .imm_ext      (imm_ext),
      .alu_sel      (alu_sel),
      .use_imm      (use_imm),
      .shift_var    (shift_var),
      .is_branch    (is_branch),
      .branch_ne    (branch_ne),
      .pc_sel_jump  (pc_sel_jump),
      .alu_out      (alu_out),
      .pc_sel       (pc_sel),
      .branch_target(branch_target),
      .jump_target  (jump_target)
   );

   writeback_stage i_writeback_stage (
      .clk       (clk),
      .rst_b     (rst_b),
      .wb_sel    (wb_sel),
      .reg_write (reg_write),
      .reg_dst_rd(reg_dst_rd),
      .rt_addr   (inst_u.r.rt),
      .rd_addr   (inst_u.r.rd),
      .alu_out   (alu_out),
      .load_data (mem_data_out),
      .imm_ext   (imm_ext),
      .pc_plus8  (pc_plus8),
      .syscall   (syscall),
      .reserved  (reserved),
      .inst_excpt(inst_excpt),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .wr_en     (wr_en),
      .halted    (halted)
   );

endmodule

// File: verif/mips_checker.sv
//*************************************************
// checker: store stream vs expected list, halt
// and fetch freeze
//*************************************************
`timescale 1ns/1ps

module mips_checker (
   input  logic            clk,
   input  logic            rst_b,
   input  logic [29:0]     inst_addr,    // fetch word address
   input  logic            mem_write,
   input  logic [29:0]     mem_addr,     // word address
   input  mips_pkg::word_t mem_data_in,
   input  logic            halted
);

   mips_pkg::word_t exp_addr [$];  // expected stores, in program order
   mips_pkg::word_t exp_data [$];
   logic [8*20-1:0] test_name;
   int              stores_seen;
   int              test_errors;
   int              error_count = 0;  // whole run
   int              test_count  = 0;
   int              fail_count  = 0;
   logic [29:0]     halt_addr;        // fetch address at the last edge
   logic            was_halted  = 1'b0;

   task start_test(input logic [8*20-1:0] name);
      test_name = name;
      exp_addr.delete();
      exp_data.delete();
      stores_seen = 0;
      test_errors = 0;
   endtask

   task expect_store(input mips_pkg::word_t addr, input mips_pkg::word_t data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task note_error();
      test_errors++;
      error_count++;
   endtask

   // called once the core has halted and settled
   task finish_test();
      test_count++;
      if (exp_addr.size() != 0) begin
         $display("test %0s: %0d expected stores never happened, first one to %h",
                  test_name, exp_addr.size(), exp_addr[0]);
         note_error();
      end
      if (test_errors == 0) begin
         $display("test %0s: pass, %0d stores matched", test_name, stores_seen);
      end else begin
         fail_count++;
         $display("test %0s: fail, %0d errors", test_name, test_errors);
      end
   endtask

   // mem_write is combinational and sampled before the edge updates
   always @(posedge clk) begin : watch_stores
      mips_pkg::word_t byte_addr;
      mips_pkg::word_t want_addr;
      mips_pkg::word_t want_data;
      if (rst_b && mem_write) begin
         byte_addr = {mem_addr, 2'b00};
         if (halted) begin
            $display("test %0s: store to %h while the core was halted", test_name, byte_addr);
            note_error();
         end else if (exp_addr.size() == 0) begin
            // e.g. a store past a syscall or in a skipped slot
            $display("test %0s: unexpected store to %h data %h", test_name, byte_addr,
                     mem_data_in);
            note_error();
         end else begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            stores_seen++;
            if (byte_addr !== want_addr || mem_data_in !== want_data) begin
               $display("CHECK FAILED at %0t: test %0s store %h data %h, expected %h data %h",
                        $time, test_name, byte_addr, mem_data_in, want_addr, want_data);
               note_error();
            end
         end
      end
   end

   // pc stays put from one edge to the next while halted
   always @(posedge clk) begin : watch_freeze
      if (rst_b && halted && was_halted && inst_addr !== halt_addr) begin
         $display("CHECK FAILED at %0t: test %0s fetch moved to %h while halted at %h",
                  $time, test_name, {inst_addr, 2'b00}, {halt_addr, 2'b00});
         note_error();
      end
      was_halted = rst_b && halted;
      halt_addr  = inst_addr;
   end

endmodule

// File: verif/tb_mips_core.sv
//*************************************************
// testbench: clock, reset, memory models,
// test data reader and run sequence
//*************************************************
`timescale 1ns/1ps

module tb_mips_core;

   localparam mips_pkg::word_t text_start = 32'h0040_0000;
   localparam int hang_limit   = 2000;  // cycles allowed until halt
   localparam int reset_cycles = 16;

   logic            clk;
   logic            rst_b;
   logic [29:0]     inst_addr;
   mips_pkg::word_t inst;
   logic            inst_excpt;
   logic [29:0]     mem_addr;
   mips_pkg::word_t mem_data_in;
   mips_pkg::word_t mem_data_out;
   logic            mem_write;
   logic            halted;

   mips_pkg::word_t imem [256];   // 0x00400000 .. 0x004003fc
   mips_pkg::word_t dmem [1024];  // 0x00000000 .. 0x00000ffc
   logic            fault_valid;
   logic [29:0]     fault_word;   // faulting fetch, word address
   int              fd;
   logic            run_broken;   // hang or bad data file

   mips_core #(
      .text_start(text_start)
   ) i_mips_core (
      .clk         (clk),
      .rst_b       (rst_b),
      .inst_addr   (inst_addr),
      .inst        (inst),
      .inst_excpt  (inst_excpt),
      .mem_addr    (mem_addr),
      .mem_data_in (mem_data_in),
      .mem_data_out(mem_data_out),
      .mem_write   (mem_write),
      .halted      (halted)
   );

   mips_checker i_mips_checker (
      .clk        (clk),
      .rst_b      (rst_b),
      .inst_addr  (inst_addr),
      .mem_write  (mem_write),
      .mem_addr   (mem_addr),
      .mem_data_in(mem_data_in),
      .halted     (halted)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns
   end

   // asynchronous memory reads
   assign inst         = imem[inst_addr[7:0]];
   assign inst_excpt   = fault_valid & (inst_addr == fault_word);
   assign mem_data_out = dmem[mem_addr[9:0]];

   always @(posedge clk) begin
      if (rst_b && mem_write)
         dmem[mem_addr[9:0]] <= mem_data_in;
   end

   // returns 1 ns past the last edge
   task wait_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
      end
      #1;
   endtask

   task clear_memories();
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0;  // nop
      end
      for (int i = 0; i < 1024; i++) begin
         dmem[i] = '0;
      end
      fault_valid = 1'b0;
      fault_word  = '0;
   endtask

   // reset stays low while the test is loaded
   task begin_test(input logic [8*20-1:0] name);
      wait_cycles(1);
      rst_b = 1'b0;
      clear_memories();
      i_mips_checker.start_test(name);
   endtask

   task run_test();
      int cycles;
      wait_cycles(reset_cycles);
      rst_b  = 1'b1;
      cycles = 0;
      while (!halted && cycles < hang_limit) begin
         wait_cycles(1);
         cycles++;
      end
      if (!halted) begin
         $display("timeout: core did not halt within %0d cycles in test %0s", hang_limit,
                  i_mips_checker.test_name);
         run_broken = 1'b1;
      end else begin
         wait_cycles(4);  // any late store shows up here
         i_mips_checker.finish_test();
      end
   endtask

   task read_records();
      logic [8*8-1:0]   tag;
      logic [8*20-1:0]  name;
      logic [8*120-1:0] line;
      mips_pkg::word_t  addr;
      mips_pkg::word_t  data;
      int               code;
      while (!run_broken && !$feof(fd)) begin
         code = $fscanf(fd, "%s", tag);
         if (code == 1) begin
            case (tag)
               "#": code = $fgets(line, fd);  // comment to end of line
               "T": begin
                  code = $fscanf(fd, "%s", name);
                  begin_test(name);
               end
               "I": begin
                  code = $fscanf(fd, "%h %h", addr, data);
                  imem[addr[9:2]] = data;
               end
               "D": begin
                  code = $fscanf(fd, "%h %h", addr, data);
                  dmem[addr[11:2]] = data;
               end
               "S": begin
                  code = $fscanf(fd, "%h %h", addr, data);
                  i_mips_checker.expect_store(addr, data);
               end
               "F": begin
                  code = $fscanf(fd, "%h", addr);
                  fault_word  = addr[31:2];
                  fault_valid = 1'b1;
               end
               "E": run_test();
               default: begin
                  $display("unknown record tag %0s in the test data file", tag);
                  run_broken = 1'b1;
               end
            endcase
         end
      end
   endtask

   initial begin
      rst_b      = 1'b0;
      run_broken = 1'b0;
      clear_memories();
      fd = $fopen("verif/mips_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open verif/mips_testdata.txt");
         run_broken = 1'b1;
      end else begin
         read_records();
         $fclose(fd);
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d", i_mips_checker.test_count,
               i_mips_checker.test_count - i_mips_checker.fail_count,
               i_mips_checker.fail_count, i_mips_checker.error_count);
      if (!run_broken && i_mips_checker.error_count == 0 && i_mips_checker.test_count > 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: files.f
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/regfile.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/mips_core.sv
verif/mips_checker.sv
verif/tb_mips_core.sv

// File: verif/mips_testdata.txt
# tags: T name | I byte_addr word | D byte_addr word | S byte_addr data (expected store)
# F byte_addr (fetch fault) | E runs the test; all numbers hex, text after # ignored
T alu_ops
I 00400000 24011234  I 00400004 ac010100  S 00000100 00001234  # addiu r1, r0, 0x1234
I 00400008 2402f0f0  I 0040000c ac020104  S 00000104 fffff0f0  # addiu r2, r0, 0xf0f0
I 00400010 00221821  I 00400014 ac030108  S 00000108 00000324  # addu r3, r1, r2 wraps
I 00400018 00412023  I 0040001c ac04010c  S 0000010c ffffdebc  # subu r4, r2, r1
I 00400020 00222824  I 00400024 ac050110  S 00000110 00001030  # and r5, r1, r2
I 00400028 00223025  I 0040002c ac060114  S 00000114 fffff2f4  # or r6, r1, r2
I 00400030 00223826  I 00400034 ac070118  S 00000118 ffffe2c4  # xor r7, r1, r2
I 00400038 00224027  I 0040003c ac08011c  S 0000011c 00000d0b  # nor r8, r1, r2
I 00400040 0041482a  I 00400044 ac090120  S 00000120 00000001  # slt r9, r2, r1
I 00400048 00015200  I 0040004c ac0a0124  S 00000124 00123400  # sll r10, r1, 8
I 00400050 00025902  I 00400054 ac0b0128  S 00000128 0fffff0f  # srl r11, r2, 4
I 00400058 00026103  I 0040005c ac0c012c  S 0000012c ffffff0f  # sra r12, r2, 4
I 00400060 01216804  I 00400064 ac0d0130  S 00000130 00002468  # sllv r13, r1, r9
I 00400068 01227006  I 0040006c ac0e0134  S 00000134 7ffff878  # srlv r14, r2, r9
I 00400070 01227807  I 00400074 ac0f0138  S 00000138 fffff878  # srav r15, r2, r9
I 00400078 30508f0f  I 0040007c ac10013c  S 0000013c 00008000  # andi r16, r2, 0x8f0f
I 00400080 34318001  I 00400084 ac110140  S 00000140 00009235  # ori r17, r1, 0x8001
I 00400088 3852ffff  I 0040008c ac120144  S 00000144 ffff0f0f  # xori r18, r2, 0xffff
I 00400090 2853f0f1  I 00400094 ac130148  S 00000148 00000001  # slti r19, r2, -0xf0f
I 00400098 0000000c  E                                         # syscall
T load_store_lui
D 00000200 00000005  D 00000204 7ffffffe
I 00400000 8c010200  I 00400004 8c020204  I 00400008 00221821  # lw r1, lw r2, addu r3
I 0040000c ac030200  S 00000200 80000003                       # store sum back over r1 word
I 00400010 8c040200  I 00400014 24840001  I 00400018 ac040208  S 00000208 80000004
I 0040001c 3c05dead  I 00400020 34a5beef  I 00400024 ac05020c  S 0000020c deadbeef
I 00400028 3c068000  I 0040002c ac060210  S 00000210 80000000  # lui r6, 0x8000
I 00400030 24000055  I 00400034 3c001234  I 00400038 8c000204  # three writes to r0
I 0040003c ac000214  S 00000214 00000000  I 00400040 00013821  # r0 still zero
I 00400044 ac070218  S 00000218 00000005  I 00400048 0000000c  E
T control_flow
I 00400000 24010001  I 00400004 24020002                       # r1 = 1, r2 = 2
I 00400008 10220008  I 0040000c 24030011  I 00400010 ac030300  S 00000300 00000011
I 00400014 14220003  I 00400018 24040022  I 0040001c 24040099  # bne taken, slot sets r4
I 00400020 24040098  I 00400024 ac040304  S 00000304 00000022
I 00400028 10210003  I 0040002c 24050033  I 00400030 24050077  # beq taken to 0x38
I 00400034 ac0503f0  I 00400038 ac050308  S 00000308 00000033  # 0x34 is skipped
I 0040003c 14210004  I 00400040 24060044  I 00400044 ac06030c  S 0000030c 00000044
I 00400048 0c100020  I 0040004c 24070055                       # jal 0x00400080
I 00400080 ac1f0310  S 00000310 00400050  I 00400084 03e00008  # link, jr r31
I 00400088 ac070314  S 00000314 00000055                       # jr slot
I 00400050 08100028  I 00400054 24080066  I 00400058 ac0803f4  # j 0x004000a0
I 004000a0 ac080318  S 00000318 00000066  I 004000a4 0000000c  E
T syscall_halt
I 00400000 24010042  I 00400004 ac010400  S 00000400 00000042
I 00400008 0000000c  I 0040000c ac010404  I 00400010 ac010408  E  # stores past syscall
T reserved_halt
I 00400000 24010031  I 00400004 ac010500  S 00000500 00000031
I 00400008 20210005  I 0040000c ac010504  E                     # addi is not kept
T fetch_fault
I 00400000 24010061  I 00400004 ac010600  S 00000600 00000061
I 00400008 ac010604  I 0040000c ac010608  F 00400008  E         # fault on the store
